//--- Bender.yml
package:
  name: lsq

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsq_pkg.sv
      - hdl/mem_req_if.sv
      - hdl/load_queue.sv
      - hdl/store_queue.sv
      - hdl/apb_mem_port.sv
      - hdl/lsq_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/lsq_assert.sv
      - tb/lsq_tb.sv

//--- hdl/apb_mem_port.sv
//////////////////////////////////////////////////
// APB requester, one access in flight
// Load request wins over a waiting store
// done follows pready in the access phase
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

module apb_mem_port import lsq_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	input  logic		pready,
	input  data_t		prdata,
	output logic		psel,
	output logic		penable,
	output logic		pwrite,
	output addr_t		paddr,
	output data_t		pwdata,
	mem_req_if.port		load_req,
	mem_req_if.port		store_req
);

	apb_state_t	state;
	logic		owner_store;	// Winner of the current access
	logic		start, pick_store, finish;

	assign start		= (state == APB_IDLE) && (load_req.req || store_req.req);
	assign pick_store	= !load_req.req;
	assign finish		= (state == APB_ACCESS) && pready;

	assign psel		= (state != APB_IDLE);
	assign penable	= (state == APB_ACCESS);

	// Completion back to the winning queue
	assign load_req.done	= finish && !owner_store;
	assign store_req.done	= finish && owner_store;
	assign load_req.rdata	= prdata;
	assign store_req.rdata	= prdata;

	////////////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= APB_IDLE;
		end else begin
			case (state)
				APB_IDLE: begin
					if (start)
						state <= APB_SETUP;
				end
				APB_SETUP: state <= APB_ACCESS;
				APB_ACCESS: begin
					if (pready)
						state <= APB_IDLE;	// Wait states hold the access
				end
				default: state <= APB_IDLE;
			endcase
		end
	end

	// Address phase registers stay put until pready
	always_ff @(posedge clock) begin
		if (start) begin
			owner_store	<= pick_store;
			pwrite		<= pick_store ? store_req.write : load_req.write;
			paddr		<= pick_store ? store_req.addr : load_req.addr;
			pwdata		<= pick_store ? store_req.wdata : load_req.wdata;
		end
	end

endmodule

//--- hdl/load_queue.sv
//////////////////////////////////////////////////
// Circular load buffer, one dispatch per cycle
// Head load reads only after all older stores drain
// An access in flight at a flush completes unused
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

module load_queue import lsq_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	input  logic		mispredict,
	input  mem_op_t		dispatch_op,
	input  data_t		base_value,
	input  prf_tag_t	base_tag,
	input  logic		base_ready,
	input  data_t		offset,
	input  rob_idx_t	rob_idx,
	input  prf_tag_t	dest_tag,
	input  logic		cdb_in_valid,
	input  prf_tag_t	cdb_in_tag,
	input  data_t		cdb_in_data,
	input  sq_ptr_t		sq_tail,
	input  sq_ptr_t		sq_head,
	output logic		lq_full,
	output logic		cdb_out_valid,
	output prf_tag_t	cdb_out_tag,
	output data_t		cdb_out_data,
	output rob_idx_t	cdb_out_rob_idx,
	mem_req_if.queue	mem
);

	localparam int IW = $clog2(`LQ_DEPTH);

	// Entry fields
	data_t		base_q		[`LQ_DEPTH];
	prf_tag_t	base_tag_q	[`LQ_DEPTH];
	logic		base_rdy_q	[`LQ_DEPTH];
	data_t		offset_q	[`LQ_DEPTH];
	rob_idx_t	rob_q		[`LQ_DEPTH];
	prf_tag_t	dest_q		[`LQ_DEPTH];
	sq_ptr_t	sq_mark_q	[`LQ_DEPTH];	// SQ tail seen at dispatch
	data_t		data_q		[`LQ_DEPTH];
	logic		loaded_q	[`LQ_DEPTH];

	lq_ptr_t		head, tail;
	logic [IW-1:0]	head_idx, tail_idx;
	logic			empty, do_disp, disp_wake, eligible;
	logic			issued;		// Request already on its way
	logic			stale;		// Head access belongs to a flushed load
	logic			keep, bcast;
	data_t			eff_addr;

	assign head_idx	= head[IW-1:0];
	assign tail_idx	= tail[IW-1:0];
	assign empty	= (head == tail);
	assign lq_full	= (head[IW] != tail[IW]) && (head_idx == tail_idx);
	assign do_disp	= (dispatch_op == OP_LOAD) && !lq_full && !mispredict;
	assign disp_wake = operand_wake(base_ready, base_tag, cdb_in_valid, cdb_in_tag);

	////////////////////////////////////////////////
	// Memory request from the head
	////////////////////////////////////////////////

	assign eligible	= base_rdy_q[head_idx] && (sq_head == sq_mark_q[head_idx]);
	assign mem.req	= !empty && !loaded_q[head_idx] && (issued || eligible);
	assign eff_addr	= base_q[head_idx] + offset_q[head_idx];
	assign mem.addr	= eff_addr[`LSQ_ADDR_W-1:0];
	assign mem.write = 1'b0;
	assign mem.wdata = '0;
	assign keep		= mem.req && !mem.done;	// Must stay up across a flush
	assign bcast	= !empty && loaded_q[head_idx] && !stale;

	always_ff @(posedge clock) begin
		if (reset) begin
			head			<= '0;
			tail			<= '0;
			issued			<= 1'b0;
			stale			<= 1'b0;
			cdb_out_valid	<= 1'b0;
		end else begin
			issued			<= keep;
			cdb_out_valid	<= 1'b0;
			if (mispredict) begin
				tail	<= head + lq_ptr_t'(keep);	// Only an access in flight survives
				stale	<= keep;
			end else begin
				if (do_disp)
					tail <= tail + 1'b1;
				if (mem.done && stale) begin
					head	<= head + 1'b1;		// Drop the discarded read
					stale	<= 1'b0;
				end else if (bcast) begin
					head			<= head + 1'b1;
					cdb_out_valid	<= 1'b1;
				end
			end
		end
	end

	// Result broadcast payload
	always_ff @(posedge clock) begin
		if (bcast) begin
			cdb_out_tag		<= dest_q[head_idx];
			cdb_out_data	<= data_q[head_idx];
			cdb_out_rob_idx	<= rob_q[head_idx];
		end
	end

	////////////////////////////////////////////////
	// Entry writes
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < `LQ_DEPTH; i++) begin
			if (operand_wake(base_rdy_q[i], base_tag_q[i], cdb_in_valid, cdb_in_tag)) begin
				base_q[i]		<= cdb_in_data;
				base_rdy_q[i]	<= 1'b1;
			end
		end
		if (mem.done && !stale) begin
			data_q[head_idx]	<= mem.rdata;
			loaded_q[head_idx]	<= 1'b1;
		end
		if (do_disp) begin
			base_q[tail_idx]		<= disp_wake ? cdb_in_data : base_value;
			base_tag_q[tail_idx]	<= base_tag;
			base_rdy_q[tail_idx]	<= base_ready || disp_wake;
			offset_q[tail_idx]		<= offset;
			rob_q[tail_idx]			<= rob_idx;
			dest_q[tail_idx]		<= dest_tag;
			sq_mark_q[tail_idx]		<= sq_tail;
			loaded_q[tail_idx]		<= 1'b0;
		end
	end

endmodule

//--- hdl/lsq_cfg.svh
//////////////////////////////////////////////////
// Widths and queue depths for the load/store queue
// Queue depths must be powers of two
// PRF and ROB sizes set the tag and index widths
//////////////////////////////////////////////////

`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

`define LSQ_DATA_W		64	// Register and memory word
`define LSQ_ADDR_W		32	// APB byte address
`define LSQ_PRF_SIZE	64	// Physical registers
`define LSQ_ROB_SIZE	32	// Reorder buffer entries

// Queue depths
`define LQ_DEPTH		8
`define SQ_DEPTH		8

`endif

//--- hdl/lsq_pkg.sv
//////////////////////////////////////////////////
// Shared types of the load/store queue
// Queue pointers carry one extra wrap bit
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

package lsq_pkg;

	typedef logic [`LSQ_DATA_W-1:0]				data_t;
	typedef logic [`LSQ_ADDR_W-1:0]				addr_t;		// Low bits of base plus offset
	typedef logic [$clog2(`LSQ_PRF_SIZE)-1:0]	prf_tag_t;
	typedef logic [$clog2(`LSQ_ROB_SIZE)-1:0]	rob_idx_t;
	typedef logic [$clog2(`LQ_DEPTH):0]			lq_ptr_t;	// MSB tells full from empty
	typedef logic [$clog2(`SQ_DEPTH):0]			sq_ptr_t;

	// Operation presented by dispatch
	typedef enum logic [1:0] {
		OP_NONE,
		OP_LOAD,
		OP_STORE
	} mem_op_t;

	// APB requester phases
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

	////////////////////////////////////////////////
	// Operand wakeup
	////////////////////////////////////////////////

	// High when a waiting operand sees its tag on a valid CDB broadcast
	function automatic logic operand_wake(
		input logic		ready,
		input prf_tag_t	tag,
		input logic		cdb_valid,
		input prf_tag_t	cdb_tag
	);
		return !ready && cdb_valid && (tag == cdb_tag);
	endfunction

endpackage

//--- hdl/lsq_top.sv
//////////////////////////////////////////////////
// Load/store queue top for one thread
// Dispatch is dropped while either queue is full
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

module lsq_top import lsq_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	input  logic		mispredict,
	// Dispatch
	input  mem_op_t		dispatch_op,
	input  data_t		base_value,
	input  prf_tag_t	base_tag,
	input  logic		base_ready,
	input  data_t		data_value,
	input  prf_tag_t	data_tag,
	input  logic		data_ready,
	input  data_t		offset,
	input  rob_idx_t	rob_idx,
	input  prf_tag_t	dest_tag,
	output logic		lsq_full,
	// CDB in and out
	input  logic		cdb_in_valid,
	input  prf_tag_t	cdb_in_tag,
	input  data_t		cdb_in_data,
	output logic		cdb_out_valid,
	output prf_tag_t	cdb_out_tag,
	output data_t		cdb_out_data,
	output rob_idx_t	cdb_out_rob_idx,
	// ROB commit
	input  rob_idx_t	rob_head,
	input  logic		rob_head_valid,
	output logic		store_done,
	output rob_idx_t	store_rob_idx,
	// APB
	output logic		psel,
	output logic		penable,
	output logic		pwrite,
	output addr_t		paddr,
	output data_t		pwdata,
	input  logic		pready,
	input  data_t		prdata
);

	logic		lq_full, sq_full;
	sq_ptr_t	sq_tail, sq_head;
	mem_op_t	disp_op;

	mem_req_if load_req ();
	mem_req_if store_req ();

	assign lsq_full	= lq_full | sq_full;
	assign disp_op	= lsq_full ? OP_NONE : dispatch_op;	// A full partner blocks both

	load_queue lq0 (
		.clock(clock), .reset(reset), .mispredict(mispredict),
		.dispatch_op(disp_op), .base_value(base_value), .base_tag(base_tag),
		.base_ready(base_ready), .offset(offset), .rob_idx(rob_idx), .dest_tag(dest_tag),
		.cdb_in_valid(cdb_in_valid), .cdb_in_tag(cdb_in_tag), .cdb_in_data(cdb_in_data),
		.sq_tail(sq_tail), .sq_head(sq_head), .lq_full(lq_full),
		.cdb_out_valid(cdb_out_valid), .cdb_out_tag(cdb_out_tag),
		.cdb_out_data(cdb_out_data), .cdb_out_rob_idx(cdb_out_rob_idx),
		.mem(load_req.queue)
	);

	store_queue sq0 (
		.clock(clock), .reset(reset), .mispredict(mispredict),
		.dispatch_op(disp_op), .base_value(base_value), .base_tag(base_tag),
		.base_ready(base_ready), .data_value(data_value), .data_tag(data_tag),
		.data_ready(data_ready), .offset(offset), .rob_idx(rob_idx),
		.cdb_in_valid(cdb_in_valid), .cdb_in_tag(cdb_in_tag), .cdb_in_data(cdb_in_data),
		.rob_head(rob_head), .rob_head_valid(rob_head_valid), .sq_full(sq_full),
		.sq_tail(sq_tail), .sq_head(sq_head), .store_done(store_done),
		.store_rob_idx(store_rob_idx), .mem(store_req.queue)
	);

	apb_mem_port apb0 (
		.clock(clock), .reset(reset), .pready(pready), .prdata(prdata),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.load_req(load_req.port), .store_req(store_req.port)
	);

endmodule

//--- hdl/mem_req_if.sv
//////////////////////////////////////////////////
// Request channel from one queue head to memory
// req, addr and wdata hold steady until done
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

interface mem_req_if import lsq_pkg::*; ();

	logic	req;	// Head wants an access
	logic	write;	// Store access
	addr_t	addr;
	data_t	wdata;
	logic	done;	// One cycle at the end of the access
	data_t	rdata;	// Valid with done

	modport queue (
		output req,
		output write,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	modport port (
		input  req,
		input  write,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

//--- hdl/store_queue.sv
//////////////////////////////////////////////////
// Circular store buffer in program order
// Head writes only as the oldest ROB instruction
// A write in flight at a flush completes silently
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

module store_queue import lsq_pkg::*; (
	input  logic		clock,
	input  logic		reset,
	input  logic		mispredict,
	input  mem_op_t		dispatch_op,
	input  data_t		base_value,
	input  prf_tag_t	base_tag,
	input  logic		base_ready,
	input  data_t		data_value,
	input  prf_tag_t	data_tag,
	input  logic		data_ready,
	input  data_t		offset,
	input  rob_idx_t	rob_idx,
	input  logic		cdb_in_valid,
	input  prf_tag_t	cdb_in_tag,
	input  data_t		cdb_in_data,
	input  rob_idx_t	rob_head,
	input  logic		rob_head_valid,
	output logic		sq_full,
	output sq_ptr_t		sq_tail,
	output sq_ptr_t		sq_head,
	output logic		store_done,
	output rob_idx_t	store_rob_idx,
	mem_req_if.queue	mem
);

	localparam int IW = $clog2(`SQ_DEPTH);

	data_t		base_q		[`SQ_DEPTH];
	prf_tag_t	base_tag_q	[`SQ_DEPTH];
	logic		base_rdy_q	[`SQ_DEPTH];
	data_t		data_q		[`SQ_DEPTH];
	prf_tag_t	data_tag_q	[`SQ_DEPTH];
	logic		data_rdy_q	[`SQ_DEPTH];
	data_t		offset_q	[`SQ_DEPTH];
	rob_idx_t	rob_q		[`SQ_DEPTH];

	logic [IW-1:0]	head_idx, tail_idx;
	logic			empty, do_disp, base_wake, data_wake, commit_ok;
	logic			issued, stale, keep;
	data_t			eff_addr;

	assign head_idx	= sq_head[IW-1:0];
	assign tail_idx	= sq_tail[IW-1:0];
	assign empty	= (sq_head == sq_tail);
	assign sq_full	= (sq_head[IW] != sq_tail[IW]) && (head_idx == tail_idx);
	assign do_disp	= (dispatch_op == OP_STORE) && !sq_full && !mispredict;
	assign base_wake = operand_wake(base_ready, base_tag, cdb_in_valid, cdb_in_tag);
	assign data_wake = operand_wake(data_ready, data_tag, cdb_in_valid, cdb_in_tag);

	// Commit check against the ROB head
	assign commit_ok = base_rdy_q[head_idx] && data_rdy_q[head_idx] &&
		rob_head_valid && (rob_head == rob_q[head_idx]);

	assign mem.req		= !empty && (issued || commit_ok);
	assign mem.write	= 1'b1;
	assign eff_addr		= base_q[head_idx] + offset_q[head_idx];
	assign mem.addr		= eff_addr[`LSQ_ADDR_W-1:0];
	assign mem.wdata	= data_q[head_idx];
	assign keep			= mem.req && !mem.done;

	////////////////////////////////////////////////
	// Pointers and completion
	////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			sq_head		<= '0;
			sq_tail		<= '0;
			issued		<= 1'b0;
			stale		<= 1'b0;
			store_done	<= 1'b0;
		end else begin
			issued		<= keep;
			store_done	<= 1'b0;
			if (mispredict) begin
				sq_tail	<= sq_head + sq_ptr_t'(keep);
				stale	<= keep;
			end else begin
				if (do_disp)
					sq_tail <= sq_tail + 1'b1;
				if (mem.done) begin
					sq_head		<= sq_head + 1'b1;
					stale		<= 1'b0;
					store_done	<= !stale;	// Flushed writes are not reported
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (mem.done)
			store_rob_idx <= rob_q[head_idx];
	end

	// Entry writes, dispatch last so it wins on the tail slot
	always_ff @(posedge clock) begin
		for (int i = 0; i < `SQ_DEPTH; i++) begin
			if (operand_wake(base_rdy_q[i], base_tag_q[i], cdb_in_valid, cdb_in_tag)) begin
				base_q[i]		<= cdb_in_data;
				base_rdy_q[i]	<= 1'b1;
			end
			if (operand_wake(data_rdy_q[i], data_tag_q[i], cdb_in_valid, cdb_in_tag)) begin
				data_q[i]		<= cdb_in_data;
				data_rdy_q[i]	<= 1'b1;
			end
		end
		if (do_disp) begin
			base_q[tail_idx]		<= base_wake ? cdb_in_data : base_value;
			base_tag_q[tail_idx]	<= base_tag;
			base_rdy_q[tail_idx]	<= base_ready || base_wake;
			data_q[tail_idx]		<= data_wake ? cdb_in_data : data_value;
			data_tag_q[tail_idx]	<= data_tag;
			data_rdy_q[tail_idx]	<= data_ready || data_wake;
			offset_q[tail_idx]		<= offset;
			rob_q[tail_idx]			<= rob_idx;
		end
	end

endmodule

//--- sources.f
+incdir+hdl
hdl/lsq_pkg.sv
hdl/mem_req_if.sv
hdl/load_queue.sv
hdl/store_queue.sv
hdl/apb_mem_port.sv
hdl/lsq_top.sv
tb/lsq_assert.sv
tb/lsq_tb.sv

//--- tb/lsq_assert.sv
//////////////////////////////////////////////////
// APB protocol and flush checks, bound into lsq_top
//////////////////////////////////////////////////

module lsq_assert import lsq_pkg::*; (
	input logic		clock,
	input logic		reset,
	input logic		mispredict,
	input logic		psel,
	input logic		penable,
	input logic		pwrite,
	input addr_t	paddr,
	input data_t	pwdata,
	input logic		pready,
	input logic		cdb_out_valid,
	input logic		store_done
);

	timeunit 1ns;
	timeprecision 100ps;

	// Address phase held from setup until pready
	property apb_hold;
		@(posedge clock) disable iff (reset)
		(psel && !(penable && pready)) |=>
			psel && $stable(paddr) && $stable(pwrite) && $stable(pwdata);
	endproperty

	// Access phase only after a selected cycle
	property enable_needs_select;
		@(posedge clock) disable iff (reset)
		penable |-> psel && $past(psel);
	endproperty

	// Nothing is reported right after a flush
	property quiet_after_flush;
		@(posedge clock) disable iff (reset)
		mispredict |=> !cdb_out_valid && !store_done;
	endproperty

	assert property (apb_hold) else $error("APB address phase changed before pready");
	assert property (enable_needs_select) else $error("penable high without a setup phase");
	assert property (quiet_after_flush) else $error("output pulse in the cycle after mispredict");

endmodule

//--- tb/lsq_tb.sv
//////////////////////////////////////////////////
// Directed testbench for lsq_top
// Memory model answers any byte address with a fill
// pattern until written, 0 to 3 wait states per access
//////////////////////////////////////////////////

`include "lsq_cfg.svh"

module lsq_tb import lsq_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int		MAX_CYCLES = 2000;	// Six tests need well under 1000 cycles
	localparam data_t	FILL = 64'h5a3c_96e1_0f87_d24b;

	logic		clock, reset, mispredict;
	mem_op_t	dispatch_op;
	data_t		base_value, data_value, offset, cdb_in_data, cdb_out_data, pwdata, prdata;
	prf_tag_t	base_tag, data_tag, dest_tag, cdb_in_tag, cdb_out_tag;
	rob_idx_t	rob_idx, rob_head, cdb_out_rob_idx, store_rob_idx;
	logic		base_ready, data_ready, lsq_full, cdb_in_valid, cdb_out_valid;
	logic		rob_head_valid, store_done, psel, penable, pwrite, pready;
	addr_t		paddr;

	int				seed = 32'hb176;
	int				errors = 0;
	int				checks = 0;
	int				cycles = 0;
	int				accesses = 0;
	int unsigned	wait_left = 0;
	logic			hold_ready = 1'b0;	// Keeps pready low in the access phase
	data_t			mem [addr_t];		// Written words only
	data_t			shadow [addr_t];	// Reference contents in program order
	data_t			res_data [$];
	prf_tag_t		res_tag [$];
	rob_idx_t		res_rob [$];
	rob_idx_t		done_rob [$];

	lsq_top dut0 (.*);

	bind lsq_top lsq_assert lsq_assert0 (
		.clock(clock), .reset(reset), .mispredict(mispredict), .psel(psel),
		.penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.pready(pready), .cdb_out_valid(cdb_out_valid), .store_done(store_done)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
		$display("Something failed");
		$finish;
	end

	// Word preset at every byte address
	function automatic data_t pattern(addr_t a);
		return data_t'(a) ^ FILL;
	endfunction

	////////////////////////////////////////////////
	// APB memory model and output monitor
	////////////////////////////////////////////////

	always @(negedge clock) begin
		pready = 1'b0;
		if (psel && penable && !hold_ready) begin
			if (wait_left == 0) begin
				pready = 1'b1;
				if (pwrite)
					mem[paddr] = pwdata;
				else
					prdata = mem.exists(paddr) ? mem[paddr] : pattern(paddr);
			end else begin
				wait_left--;
			end
		end
	end

	always @(posedge clock) begin
		if (cdb_out_valid) begin
			res_data.push_back(cdb_out_data);
			res_tag.push_back(cdb_out_tag);
			res_rob.push_back(cdb_out_rob_idx);
		end
		if (store_done)
			done_rob.push_back(store_rob_idx);
		if (psel && !penable) begin		// Setup phase picks the wait states
			accesses++;
			wait_left = {$random(seed)} % 4;
		end
	end

	////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////

	task automatic check_data(string name, data_t got, data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_tag(string name, prf_tag_t got, prf_tag_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rob(string name, rob_idx_t got, rob_idx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic note_failure(string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic expect_result(data_t exp_data, prf_tag_t exp_tag, rob_idx_t exp_rob);
		while (res_data.size() == 0)
			@(negedge clock);
		check_data("cdb_out_data", res_data.pop_front(), exp_data);
		check_tag("cdb_out_tag", res_tag.pop_front(), exp_tag);
		check_rob("cdb_out_rob_idx", res_rob.pop_front(), exp_rob);
	endtask

	task automatic expect_store_done(rob_idx_t exp_rob);
		while (done_rob.size() == 0)
			@(negedge clock);
		check_rob("store_rob_idx", done_rob.pop_front(), exp_rob);
	endtask

	////////////////////////////////////////////////
	// Dispatch and CDB drivers, called at a falling edge
	////////////////////////////////////////////////

	task automatic send_load(data_t base, prf_tag_t btag, logic brdy, data_t off,
			rob_idx_t rob, prf_tag_t dest);
		dispatch_op = OP_LOAD;
		base_value = base;
		base_tag = btag;
		base_ready = brdy;
		offset = off;
		rob_idx = rob;
		dest_tag = dest;
		@(negedge clock);
		dispatch_op = OP_NONE;
	endtask

	task automatic send_store(data_t base, prf_tag_t btag, logic brdy, data_t value,
			prf_tag_t dtag, logic drdy, data_t off, rob_idx_t rob);
		dispatch_op = OP_STORE;
		base_value = base;
		base_tag = btag;
		base_ready = brdy;
		data_value = value;
		data_tag = dtag;
		data_ready = drdy;
		offset = off;
		rob_idx = rob;
		@(negedge clock);
		dispatch_op = OP_NONE;
	endtask

	task automatic broadcast(prf_tag_t tag, data_t value);
		cdb_in_valid = 1'b1;
		cdb_in_tag = tag;
		cdb_in_data = value;
		@(negedge clock);
		cdb_in_valid = 1'b0;
	endtask

	////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////

	task automatic single_load_test();
		send_load(64'h1000, 6'd0, 1'b1, 64'h18, 5'd1, 6'd5);
		expect_result(pattern(32'h1018), 6'd5, 5'd1);
	endtask

	task automatic store_then_load_test();
		int		acc0;
		data_t	value;
		value = 64'hdead_beef_0123_4567;
		rob_head = 5'd0;
		rob_head_valid = 1'b1;
		acc0 = accesses;
		send_store(64'h2000, 6'd0, 1'b1, value, 6'd0, 1'b1, 64'h8, 5'd3);
		send_load(64'h2000, 6'd0, 1'b1, 64'h8, 5'd4, 6'd7);
		repeat (20) @(negedge clock);
		if (accesses != acc0)
			note_failure("APB access before the store reached the ROB head");
		rob_head = 5'd3;
		expect_store_done(5'd3);
		expect_result(value, 6'd7, 5'd4);
	endtask

	task automatic wakeup_test();
		int acc0;
		acc0 = accesses;
		send_load(64'h0, 6'd12, 1'b0, 64'h40, 5'd5, 6'd9);
		repeat (10) @(negedge clock);
		if (accesses != acc0 || res_data.size() != 0)
			note_failure("load went to memory before its base tag was broadcast");
		broadcast(6'd12, 64'h3000);
		expect_result(pattern(32'h3040), 6'd9, 5'd5);
	endtask

	task automatic backpressure_test();
		hold_ready = 1'b1;
		for (int i = 0; i < `LQ_DEPTH; i++)
			send_load(data_t'(32'h4000 + 8 * i), 6'd0, 1'b1, 64'h0,
				rob_idx_t'(8 + i), prf_tag_t'(16 + i));
		if (!lsq_full)
			note_failure("lsq_full stayed low with the load queue full");
		send_load(64'h4800, 6'd0, 1'b1, 64'h0, 5'd30, 6'd40);	// Dropped
		repeat (5) @(negedge clock);
		hold_ready = 1'b0;
		for (int i = 0; i < `LQ_DEPTH; i++)
			expect_result(pattern(addr_t'(32'h4000 + 8 * i)), prf_tag_t'(16 + i),
				rob_idx_t'(8 + i));
		repeat (20) @(negedge clock);
		if (res_data.size() != 0)
			note_failure("result came out for a dispatch made while lsq_full was high");
	endtask

	task automatic flush_test();
		int acc0;
		acc0 = accesses;
		rob_head_valid = 1'b0;
		hold_ready = 1'b1;
		send_load(64'h0, 6'd0, 1'b1, 64'h8, 5'd20, 6'd49);	// Stalls on the bus
		send_load(64'h0, 6'd20, 1'b0, 64'h10, 5'd21, 6'd50);
		send_store(64'h0, 6'd21, 1'b0, 64'h0, 6'd22, 1'b0, 64'h18, 5'd22);
		send_load(64'h0, 6'd23, 1'b0, 64'h20, 5'd23, 6'd51);
		hold_ready = 1'b0;
		do
			@(posedge clock);
		while (!(penable && pready));
		@(negedge clock);
		mispredict = 1'b1;		// Same cycle as the head result broadcast
		@(negedge clock);
		mispredict = 1'b0;
		for (int t = 20; t < 24; t++)
			broadcast(prf_tag_t'(t), 64'h6000);
		rob_head = 5'd22;		// A surviving store would commit now
		rob_head_valid = 1'b1;
		repeat (30) @(negedge clock);
		if (accesses != acc0 + 1 || res_data.size() != 0 || done_rob.size() != 0)
			note_failure("flushed instructions still reached memory or the outputs");
		if (lsq_full)
			note_failure("lsq_full high after the flush");
	endtask

	task automatic random_wait_test();
		addr_t	a;
		data_t	value;
		data_t	exp_data [$];
		int		ids [$];
		for (int i = 0; i < 16; i++) begin
			a = addr_t'(32'h5000 + 8 * ({$random(seed)} % 4));
			while (lsq_full)
				@(negedge clock);
			if ($random(seed) & 1) begin
				while (res_data.size() < exp_data.size())
					@(negedge clock);		// Older loads retire first
				value = {$random(seed), $random(seed)};
				shadow[a] = value;
				rob_head = rob_idx_t'(i);
				send_store(data_t'(a), 6'd0, 1'b1, value, 6'd0, 1'b1, 64'h0, rob_idx_t'(i));
				expect_store_done(rob_idx_t'(i));
			end else begin
				exp_data.push_back(shadow.exists(a) ? shadow[a] : pattern(a));
				ids.push_back(i);
				send_load(data_t'(a), 6'd0, 1'b1, 64'h0, rob_idx_t'(i), prf_tag_t'(i));
			end
		end
		foreach (exp_data[k])
			expect_result(exp_data[k], prf_tag_t'(ids[k]), rob_idx_t'(ids[k]));
	endtask

	initial begin
		reset = 1'b1;
		mispredict = 1'b0;
		dispatch_op = OP_NONE;
		base_value = '0;
		base_tag = '0;
		base_ready = 1'b0;
		data_value = '0;
		data_tag = '0;
		data_ready = 1'b0;
		offset = '0;
		rob_idx = '0;
		dest_tag = '0;
		cdb_in_valid = 1'b0;
		cdb_in_tag = '0;
		cdb_in_data = '0;
		rob_head = '0;
		rob_head_valid = 1'b0;
		pready = 1'b0;
		prdata = '0;
		repeat (8) @(negedge clock);
		reset = 1'b0;
		if (psel || penable || cdb_out_valid || store_done || lsq_full)
			note_failure("outputs not idle after reset");
		single_load_test();
		store_then_load_test();
		wakeup_test();
		backpressure_test();
		flush_test();
		random_wait_test();
		@(negedge clock);
		$display("%0d checks, %0d errors, %0d APB accesses", checks, errors, accesses);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
